//--- hw/ipdc_pkg.sv
package ipdc_pkg;

	// ----------------------------------------
	// image and window geometry
	// ----------------------------------------
	localparam int IMG_DIM     = 8;
	localparam int IMG_PIXELS  = IMG_DIM * IMG_DIM;
	localparam int WIN_DIM     = 4;
	localparam int WIN_PIXELS  = WIN_DIM * WIN_DIM;
	localparam int ADDR_W      = 6;
	localparam int WIN_CNT_W   = 4;
	// row 2, column 2
	localparam int ZOOM_ORIGIN = 18;

	// pixel word widths
	localparam int CHAN_W = 8;
	localparam int PIX_W  = 3 * CHAN_W;

	// ----------------------------------------
	// opcodes
	// ----------------------------------------
	typedef enum logic [2:0] {
		LOAD   = 3'd0,
		RIGHT  = 3'd1,
		DOWN   = 3'd2,
		HOME   = 3'd3,
		ZOOM   = 3'd4,
		MEDIAN = 3'd5,
		YCC    = 3'd6,
		RGB    = 3'd7
	} op_mode_e;

	// ----------------------------------------
	// pixel formats
	// ----------------------------------------
	// r sits in the low byte
	typedef struct packed {
		logic [CHAN_W-1:0] b;
		logic [CHAN_W-1:0] g;
		logic [CHAN_W-1:0] r;
	} rgb_t;

	// y sits in the low byte, cr on top
	typedef struct packed {
		logic [CHAN_W-1:0] cr;
		logic [CHAN_W-1:0] cb;
		logic [CHAN_W-1:0] y;
	} ycc_t;

	// one output word, read per the current colour mode
	typedef union packed {
		rgb_t rgb;
		ycc_t ycc;
	} pixel_u;

	// one-cycle origin move strobes
	typedef struct packed {
		logic shift_right;
		logic shift_down;
		logic go_home;
		logic go_zoom;
	} origin_cmd_t;

endpackage

//--- hw/ipdc_ctrl.sv
`timescale 1ns/10ps

module ipdc_ctrl (
	input  logic                         i_clk,
	input  logic                         i_rst_n,
	input  logic                         i_op_valid,
	input  ipdc_pkg::op_mode_e           i_op_mode,
	input  logic                         i_in_valid,
	output logic                         o_in_ready,
	output logic                         o_wr_en,
	output logic [ipdc_pkg::ADDR_W-1:0]    o_wr_addr,
	output ipdc_pkg::origin_cmd_t        o_origin_cmd,
	output logic                         o_rd_en,
	output logic [ipdc_pkg::WIN_CNT_W-1:0] o_win_idx,
	output logic                         o_ycc_mode
);

	import ipdc_pkg::*;

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_LOAD,
		ST_DISPLAY
	} state_e;

	state_e              state;
	// shared by load address and window index
	logic [ADDR_W-1:0]   cnt;
	// low for the first display cycle, then high for 16 reads
	logic                rd_q;
	logic                ycc_q;
	logic                accept;

	// ----------------------------------------
	// op acceptance and origin decode
	// ----------------------------------------
	// ops only taken while idle, load ignores them
	assign accept = (state == ST_IDLE) && i_op_valid;

	always_comb begin
		o_origin_cmd = '0;
		if (accept) begin
			case (i_op_mode)
				RIGHT: o_origin_cmd.shift_right = 1'b1;
				DOWN:  o_origin_cmd.shift_down  = 1'b1;
				HOME:  o_origin_cmd.go_home     = 1'b1;
				ZOOM:  o_origin_cmd.go_zoom     = 1'b1;
				default: ;
			endcase
		end
	end

	// ----------------------------------------
	// state, counter, mode
	// ----------------------------------------
	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			state <= ST_IDLE;
			cnt   <= '0;
			rd_q  <= 1'b0;
			ycc_q <= 1'b0;
		end else begin
			case (state)
				ST_IDLE: begin
					if (accept) begin
						case (i_op_mode)
							LOAD: begin
								state <= ST_LOAD;
								cnt   <= '0;
							end
							RIGHT, DOWN, HOME, ZOOM: begin
								state <= ST_DISPLAY;
								cnt   <= '0;
								rd_q  <= 1'b0;
							end
							YCC: ycc_q <= 1'b1;
							RGB: ycc_q <= 1'b0;
							// median kept as a no-op
							default: ;
						endcase
					end
				end
				ST_LOAD: begin
					if (i_in_valid) begin
						if (cnt == ADDR_W'(IMG_PIXELS - 1)) begin
							state <= ST_IDLE;
							cnt   <= '0;
						end else begin
							cnt <= cnt + 1'b1;
						end
					end
				end
				ST_DISPLAY: begin
					// origin settles in the gap cycle before the first read
					if (!rd_q) begin
						rd_q <= 1'b1;
					end else if (cnt == ADDR_W'(WIN_PIXELS - 1)) begin
						state <= ST_IDLE;
						rd_q  <= 1'b0;
						cnt   <= '0;
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	// ready while idle or loading
	assign o_in_ready = (state != ST_DISPLAY);
	assign o_wr_en    = (state == ST_LOAD) && i_in_valid;
	assign o_wr_addr  = cnt;
	assign o_rd_en    = rd_q;
	assign o_win_idx  = cnt[WIN_CNT_W-1:0];
	assign o_ycc_mode = ycc_q;

endmodule

//--- hw/image_buffer.sv
`timescale 1ns/10ps

module image_buffer (
	input  logic                      i_clk,
	input  logic                      i_rst_n,
	input  logic                      i_wr_en,
	input  logic [ipdc_pkg::ADDR_W-1:0] i_wr_addr,
	input  ipdc_pkg::pixel_u          i_wr_data,
	input  logic [ipdc_pkg::ADDR_W-1:0] i_rd_addr,
	output ipdc_pkg::pixel_u          o_rd_data
);

	import ipdc_pkg::*;

	// 8x8 image, row-major
	pixel_u mem [IMG_PIXELS];

	// ----------------------------------------
	// write port
	// ----------------------------------------
	// image starts black after reset
	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			for (int i = 0; i < IMG_PIXELS; i++) begin
				mem[i] <= '0;
			end
		end else if (i_wr_en) begin
			mem[i_wr_addr] <= i_wr_data;
		end
	end

	// ----------------------------------------
	// read port
	// ----------------------------------------
	// combinational, registered later in color_convert
	assign o_rd_data = mem[i_rd_addr];

endmodule

//--- hw/window_origin.sv
`timescale 1ns/10ps

module window_origin (
	input  logic                         i_clk,
	input  logic                         i_rst_n,
	input  ipdc_pkg::origin_cmd_t        i_cmd,
	input  logic [ipdc_pkg::WIN_CNT_W-1:0] i_win_idx,
	output logic [ipdc_pkg::ADDR_W-1:0]    o_rd_addr
);

	import ipdc_pkg::*;

	logic [ADDR_W-1:0]   origin;
	// origin split into row and column
	logic [ADDR_W/2-1:0] org_col;
	logic [ADDR_W/2-1:0] org_row;
	logic [ADDR_W-1:0]   win_off;

	assign org_col = origin[ADDR_W/2-1:0];
	assign org_row = origin[ADDR_W-1:ADDR_W/2];

	// ----------------------------------------
	// origin register with clamped moves
	// ----------------------------------------
	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			origin <= '0;
		end else if (i_cmd.go_home) begin
			origin <= '0;
		end else if (i_cmd.go_zoom) begin
			origin <= ADDR_W'(ZOOM_ORIGIN);
		end else if (i_cmd.shift_right) begin
			// window must stay inside the image
			if (org_col < (IMG_DIM - WIN_DIM)) begin
				origin <= origin + 1'b1;
			end
		end else if (i_cmd.shift_down) begin
			if (org_row < (IMG_DIM - WIN_DIM)) begin
				origin <= origin + ADDR_W'(IMG_DIM);
			end
		end
	end

	// ----------------------------------------
	// window index to image address
	// ----------------------------------------
	// upper index bits pick the row, lower ones the column
	assign win_off = ADDR_W'(i_win_idx[WIN_CNT_W-1:WIN_CNT_W/2]) * ADDR_W'(IMG_DIM)
		+ ADDR_W'(i_win_idx[WIN_CNT_W/2-1:0]);

	assign o_rd_addr = origin + win_off;

endmodule

//--- hw/color_convert.sv
`timescale 1ns/10ps

module color_convert (
	input  logic             i_clk,
	input  logic             i_rst_n,
	input  logic             i_rd_en,
	input  logic             i_ycc_mode,
	input  ipdc_pkg::pixel_u i_pixel,
	output logic             o_out_valid,
	output ipdc_pkg::pixel_u o_out_data
);

	import ipdc_pkg::*;

	// 12-bit signed covers every intermediate sum
	logic signed [11:0] r_s;
	logic signed [11:0] g_s;
	logic signed [11:0] b_s;
	logic signed [11:0] y_sum;
	logic signed [11:0] cb_sum;
	logic signed [11:0] cr_sum;
	pixel_u             conv;
	pixel_u             out_q;
	logic               valid_q;

	// clamp to one unsigned channel
	function automatic logic [CHAN_W-1:0] sat_chan(input logic signed [11:0] v);
		if (v < 0) begin
			return '0;
		end else if (v > 255) begin
			return '1;
		end
		return v[CHAN_W-1:0];
	endfunction

	// ----------------------------------------
	// fixed-point conversion
	// ----------------------------------------
	always_comb begin
		r_s = {4'b0, i_pixel.rgb.r};
		g_s = {4'b0, i_pixel.rgb.g};
		b_s = {4'b0, i_pixel.rgb.b};
		// eighths, +4 rounds half up
		y_sum  = (r_s <<< 1) + (g_s <<< 2) + g_s + 12'sd4;
		cb_sum = (b_s <<< 2) - r_s - (g_s <<< 1) + 12'sd4;
		cr_sum = (r_s <<< 2) - (g_s <<< 1) - g_s - b_s + 12'sd4;
		// arithmetic shift floors negative sums
		conv.ycc.y  = sat_chan(y_sum >>> 3);
		conv.ycc.cb = sat_chan((cb_sum >>> 3) + 12'sd128);
		conv.ycc.cr = sat_chan((cr_sum >>> 3) + 12'sd128);
	end

	// ----------------------------------------
	// output register
	// ----------------------------------------
	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			valid_q <= 1'b0;
			out_q   <= '0;
		end else begin
			valid_q <= i_rd_en;
			// data bus idles at zero between beats
			if (!i_rd_en) begin
				out_q <= '0;
			end else if (i_ycc_mode) begin
				out_q <= conv;
			end else begin
				out_q <= i_pixel;
			end
		end
	end

	assign o_out_valid = valid_q;
	assign o_out_data  = out_q;

endmodule

//--- hw/ipdc_top.sv
`timescale 1ns/10ps

module ipdc_top (
	input  logic               i_clk,
	input  logic               i_rst_n,
	input  logic               i_op_valid,
	input  ipdc_pkg::op_mode_e i_op_mode,
	input  logic               i_in_valid,
	input  ipdc_pkg::pixel_u   i_in_data,
	output logic               o_in_ready,
	output logic               o_out_valid,
	output ipdc_pkg::pixel_u   o_out_data
);

	import ipdc_pkg::*;

	// ----------------------------------------
	// internal nets
	// ----------------------------------------
	logic                 wr_en;
	logic [ADDR_W-1:0]    wr_addr;
	origin_cmd_t          origin_cmd;
	logic                 rd_en;
	logic [WIN_CNT_W-1:0] win_idx;
	logic                 ycc_mode;
	logic [ADDR_W-1:0]    rd_addr;
	pixel_u               rd_data;

	// op decode, counters, mode
	ipdc_ctrl u_ctrl (
		.i_clk        (i_clk),
		.i_rst_n      (i_rst_n),
		.i_op_valid   (i_op_valid),
		.i_op_mode    (i_op_mode),
		.i_in_valid   (i_in_valid),
		.o_in_ready   (o_in_ready),
		.o_wr_en      (wr_en),
		.o_wr_addr    (wr_addr),
		.o_origin_cmd (origin_cmd),
		.o_rd_en      (rd_en),
		.o_win_idx    (win_idx),
		.o_ycc_mode   (ycc_mode)
	);

	// pixel store, load data comes straight in
	image_buffer u_buf (
		.i_clk     (i_clk),
		.i_rst_n   (i_rst_n),
		.i_wr_en   (wr_en),
		.i_wr_addr (wr_addr),
		.i_wr_data (i_in_data),
		.i_rd_addr (rd_addr),
		.o_rd_data (rd_data)
	);

	window_origin u_origin (
		.i_clk     (i_clk),
		.i_rst_n   (i_rst_n),
		.i_cmd     (origin_cmd),
		.i_win_idx (win_idx),
		.o_rd_addr (rd_addr)
	);

	color_convert u_conv (
		.i_clk       (i_clk),
		.i_rst_n     (i_rst_n),
		.i_rd_en     (rd_en),
		.i_ycc_mode  (ycc_mode),
		.i_pixel     (rd_data),
		.o_out_valid (o_out_valid),
		.o_out_data  (o_out_data)
	);

endmodule

//--- verif/ipdc_assert.sv
`timescale 1ns/10ps

module ipdc_assert (
	input logic               i_clk,
	input logic               i_rst_n,
	input logic               i_op_valid,
	input ipdc_pkg::op_mode_e i_op_mode,
	input logic               o_in_ready,
	input logic               o_out_valid
);

	import ipdc_pkg::*;

	// beats seen so far in the current output run
	logic [4:0] run_len;
	logic       disp_accept;

	// display ops only, the other opcodes stay quiet
	assign disp_accept = i_op_valid && o_in_ready
		&& (i_op_mode inside {RIGHT, DOWN, HOME, ZOOM});

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			run_len <= '0;
		end else if (o_out_valid) begin
			run_len <= run_len + 1'b1;
		end else begin
			run_len <= '0;
		end
	end

	// ----------------------------------------
	// output protocol
	// ----------------------------------------
	a_quiet_in_reset: assert property (@(posedge i_clk) !i_rst_n |-> !o_out_valid)
		else $error("o_out_valid high while reset is asserted");

	// a run that ends must have been a full window
	a_run_full: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		(!o_out_valid && run_len != 0) |-> run_len == 5'd16)
		else $error("o_out_valid run ended after %0d beats", run_len);

	a_run_max: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		o_out_valid |-> run_len < 5'd16)
		else $error("o_out_valid run longer than a window");

	// busy from the cycle after accept until the first beat
	a_busy: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		disp_accept |=> (!o_in_ready && !o_out_valid) ##1 (!o_in_ready && !o_out_valid)
		##1 (!o_in_ready && o_out_valid))
		else $error("o_in_ready high or early beat after a display op");

endmodule

bind ipdc_top ipdc_assert u_assert (
	.i_clk       (i_clk),
	.i_rst_n     (i_rst_n),
	.i_op_valid  (i_op_valid),
	.i_op_mode   (i_op_mode),
	.o_in_ready  (o_in_ready),
	.o_out_valid (o_out_valid)
);

//--- verif/ipdc_tb.sv
`timescale 1ns/10ps

module ipdc_tb;

	import ipdc_pkg::*;

	localparam int READY_LIMIT  = 64;
	localparam int RUN_LIMIT    = 40;
	localparam int QUIET_CYCLES = 20;

	logic     clk;
	logic     rst_n;
	logic     op_valid;
	op_mode_e op_mode;
	logic     in_valid;
	pixel_u   in_data;
	logic     in_ready;
	logic     out_valid;
	pixel_u   out_data;

	// reference image, origin and mode
	logic [PIX_W-1:0] img [IMG_PIXELS];
	logic [PIX_W-1:0] exp_q [$];
	logic [PIX_W-1:0] exp_word;
	logic [31:0]      rng;
	int               ref_row;
	int               ref_col;
	bit               ref_ycc;
	int               beats;
	int               checks;
	int               errors;
	int               timeouts;

	ipdc_top DUT (
		.i_clk       (clk),
		.i_rst_n     (rst_n),
		.i_op_valid  (op_valid),
		.i_op_mode   (op_mode),
		.i_in_valid  (in_valid),
		.i_in_data   (in_data),
		.o_in_ready  (in_ready),
		.o_out_valid (out_valid),
		.o_out_data  (out_data)
	);

	always #20 clk = ~clk;

	// ----------------------------------------
	// reference model
	// ----------------------------------------
	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// division by 8 that floors negative sums too
	function automatic int floor_div8(input int v);
		if (v >= 0) begin
			return v / 8;
		end
		return -((-v + 7) / 8);
	endfunction

	function automatic int clamp_byte(input int v);
		if (v < 0) begin
			return 0;
		end else if (v > 255) begin
			return 255;
		end
		return v;
	endfunction

	// raw pixel in rgb mode and {cr, cb, y} in ycc mode
	function automatic logic [PIX_W-1:0] expected_pixel(input logic [PIX_W-1:0] pix,
		input bit ycc);
		int r;
		int g;
		int b;
		int y;
		int cb;
		int cr;
		if (!ycc) begin
			return pix;
		end
		r  = int'(pix[7:0]);
		g  = int'(pix[15:8]);
		b  = int'(pix[23:16]);
		y  = clamp_byte((2 * r + 5 * g + 4) / 8);
		cb = clamp_byte(128 + floor_div8(4 * b - r - 2 * g + 4));
		cr = clamp_byte(128 + floor_div8(4 * r - 3 * g - b + 4));
		return {cr[7:0], cb[7:0], y[7:0]};
	endfunction

	// corner colours inside the zoom window
	function automatic logic [PIX_W-1:0] test_pixel(input int a, input logic [PIX_W-1:0] rnd);
		case (a)
			18: return 24'hff0000;   // pure blue drives cb past 255
			19: return 24'h0000ff;   // pure red drives cr past 255
			20: return 24'hffff00;   // cyan gives the lowest cr
			21: return 24'h00ffff;   // yellow gives the lowest cb
			26: return 24'hffffff;
			27: return 24'h000000;
			default: return rnd;
		endcase
	endfunction

	task automatic move_origin(input op_mode_e m);
		case (m)
			RIGHT: if (ref_col < IMG_DIM - WIN_DIM) ref_col++;
			DOWN:  if (ref_row < IMG_DIM - WIN_DIM) ref_row++;
			HOME: begin
				ref_row = 0;
				ref_col = 0;
			end
			ZOOM: begin
				ref_row = ZOOM_ORIGIN / IMG_DIM;
				ref_col = ZOOM_ORIGIN % IMG_DIM;
			end
			default: ;
		endcase
	endtask

	task automatic queue_window();
		int a;
		for (int i = 0; i < WIN_PIXELS; i++) begin
			a = (ref_row + i / WIN_DIM) * IMG_DIM + ref_col + i % WIN_DIM;
			exp_q.push_back(expected_pixel(img[a], ref_ycc));
		end
	endtask

	// ----------------------------------------
	// output checker
	// ----------------------------------------
	always @(negedge clk) begin
		if (rst_n && out_valid) begin
			checks++;
			assert (exp_q.size() != 0) else begin
				$display("error at %0t: output beat with nothing expected", $time);
				errors++;
			end
			if (exp_q.size() != 0) begin
				exp_word = exp_q.pop_front();
				assert (out_data == exp_word) else begin
					$display("error at %0t: pixel got %06h expected %06h",
						$time, out_data, exp_word);
					errors++;
				end
			end
			beats++;
		end else if (rst_n) begin
			// bus idles at zero
			assert (out_data == '0) else begin
				$display("error at %0t: o_out_data %06h while idle", $time, out_data);
				errors++;
			end
		end
	end

	// ----------------------------------------
	// stimulus tasks driven at posedge + 2
	// ----------------------------------------
	task automatic wait_ready();
		int n;
		n = 0;
		while (!in_ready && n < READY_LIMIT) begin
			@(posedge clk);
			#2;
			n++;
		end
		if (!in_ready) begin
			$display("timeout: o_in_ready stayed low for %0d cycles", READY_LIMIT);
			timeouts++;
		end
	endtask

	task automatic issue_op(input op_mode_e m);
		if (timeouts != 0) return;
		wait_ready();
		if (timeouts != 0) return;
		op_valid = 1'b1;
		op_mode  = m;
		@(posedge clk);
		#2;
		op_valid = 1'b0;
	endtask

	task automatic load_image(input bit with_corners);
		logic [PIX_W-1:0] pix;
		if (timeouts != 0) return;
		issue_op(LOAD);
		for (int a = 0; a < IMG_PIXELS && timeouts == 0; a++) begin
			// in_valid is a level and drops now and then
			if (a % 16 == 15) begin
				in_valid = 1'b0;
				@(posedge clk);
				#2;
			end
			rng = xorshift32(rng);
			pix = with_corners ? test_pixel(a, rng[PIX_W-1:0]) : rng[PIX_W-1:0];
			img[a]   = pix;
			in_valid = 1'b1;
			in_data  = pix;
			checks++;
			assert (in_ready) else begin
				$display("error at %0t: o_in_ready low during load", $time);
				errors++;
			end
			@(posedge clk);
			#2;
		end
		in_valid = 1'b0;
	endtask

	task automatic display_window(input op_mode_e m);
		int target;
		int n;
		if (timeouts != 0) return;
		move_origin(m);
		queue_window();
		target = beats + WIN_PIXELS;
		issue_op(m);
		n = 0;
		while (beats < target && n < RUN_LIMIT && timeouts == 0) begin
			@(posedge clk);
			#2;
			n++;
		end
		if (beats < target && timeouts == 0) begin
			$display("timeout: window output stopped after %0d of %0d pixels",
				WIN_PIXELS - (target - beats), WIN_PIXELS);
			timeouts++;
		end
	endtask

	// ops that must not start a display
	task automatic check_quiet(input op_mode_e m);
		int start_beats;
		if (timeouts != 0) return;
		start_beats = beats;
		if (m == YCC) ref_ycc = 1'b1;
		if (m == RGB) ref_ycc = 1'b0;
		issue_op(m);
		repeat (QUIET_CYCLES) begin
			@(posedge clk);
			#2;
			checks++;
			assert (in_ready) else begin
				$display("error at %0t: o_in_ready low after %s", $time, m.name());
				errors++;
			end
		end
		checks++;
		assert (beats == start_beats) else begin
			$display("error at %0t: %s produced %0d beats",
				$time, m.name(), beats - start_beats);
			errors++;
		end
	endtask

	// ----------------------------------------
	// test sequence
	// ----------------------------------------
	initial begin
		clk      = 1'b0;
		rst_n    = 1'b0;
		op_valid = 1'b0;
		op_mode  = LOAD;
		in_valid = 1'b0;
		in_data  = '0;
		rng      = 32'h2f612101;
		ref_row  = 0;
		ref_col  = 0;
		ref_ycc  = 1'b0;
		beats    = 0;
		checks   = 0;
		errors   = 0;
		timeouts = 0;
		for (int a = 0; a < IMG_PIXELS; a++) begin
			img[a] = '0;
		end
		repeat (4) @(posedge clk);
		#2;
		rst_n = 1'b1;
		@(negedge clk);
		checks++;
		assert (in_ready && !out_valid && out_data == '0) else begin
			$display("error at %0t: outputs not at reset values", $time);
			errors++;
		end
		@(posedge clk);
		#2;
		// first image with corner colours and its home window
		load_image(1'b1);
		display_window(HOME);
		// right and down both clamp at 4
		repeat (5) display_window(RIGHT);
		repeat (5) display_window(DOWN);
		// zoom raw and then converted
		display_window(ZOOM);
		check_quiet(YCC);
		display_window(ZOOM);
		display_window(HOME);
		check_quiet(MEDIAN);
		check_quiet(YCC);
		check_quiet(RGB);
		display_window(HOME);
		// fresh image replaces the old one
		load_image(1'b0);
		display_window(HOME);
		repeat (4) @(posedge clk);
		checks++;
		assert (exp_q.size() == 0) else begin
			$display("error at %0t: %0d expected pixels never came out",
				$time, exp_q.size());
			errors++;
		end
		$display("summary: %0d checks, %0d errors, %0d timeouts", checks, errors, timeouts);
		if (errors == 0 && timeouts == 0) begin
			$display("Finished with no errors");
		end else begin
			$display("Finished with errors");
		end
		$finish;
	end

endmodule

//--- build.f
hw/ipdc_pkg.sv
hw/ipdc_ctrl.sv
hw/image_buffer.sv
hw/window_origin.sv
hw/color_convert.sv
hw/ipdc_top.sv
verif/ipdc_assert.sv
verif/ipdc_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the ipdc testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	--top-module ipdc_tb --Mdir obj_dir -o ipdc_sim -f build.f
status=$?
if [ $status -ne 0 ]; then
	echo "verilator build failed with status $status"
	exit 1
fi

out=$(./obj_dir/ipdc_sim 2>&1)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$out" | grep -qx "Finished with no errors"; then
	exit 0
fi
echo "simulation did not pass"
exit 1
